// ==== memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8;   // one enable per byte lane
    localparam int REG_W  = 5;
    localparam int EXC_W  = 5;
    localparam int OP_W   = 3;

    typedef logic [DATA_W-1:0] dataWord_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BE_W-1:0]   byteEn_t;    // bit n -> bits 8n+7:8n
    typedef logic [REG_W-1:0]  regNum_t;
    typedef logic [EXC_W-1:0]  excCode_t;

    // access kinds seen by the memory step
    typedef enum logic [OP_W-1:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } memOp_t;

    // cause codes for address errors
    localparam excCode_t EXC_ADEL = 5'd4;   // load / fetch
    localparam excCode_t EXC_ADES = 5'd5;   // store

    typedef struct packed {
        memOp_t    op;
        addr_t     addr;
        dataWord_t storeData;   // raw rt value, not yet lane aligned
        regNum_t   dest;
    } memReq_t;

    typedef struct packed {
        logic      regWrite;
        regNum_t   dest;
        dataWord_t data;
        logic      excValid;
        excCode_t  excCode;
        addr_t     badVAddr;
    } memResp_t;

    typedef struct packed {
        addr_t     addr;    // word aligned
        byteEn_t   wen;     // zero on a read
        dataWord_t wdata;
    } busReq_t;

endpackage

`default_nettype wire

// ==== laneMapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module laneMapper import memPkg::*; (
    input  memReq_t   req,
    output byteEn_t   laneEn,
    output dataWord_t laneData,
    output logic      misaligned
);

    logic [1:0] offset;
    logic       isByte;
    logic       isHalf;
    logic       isWord;

    assign offset = req.addr[1:0];

    always_comb begin
        isByte = 1'b0;
        isHalf = 1'b0;
        isWord = 1'b0;
        unique case (req.op)
            LB, LBU, SB: isByte = 1'b1;
            LH, LHU, SH: isHalf = 1'b1;
            default:     isWord = 1'b1;   // LW, SW
        endcase
    end

    // byte enables, little endian lanes
    always_comb begin
        if (isByte) begin
            laneEn = byteEn_t'(4'b0001) << offset;
        end else if (isHalf) begin
            laneEn = offset[1] ? byteEn_t'(4'b1100) : byteEn_t'(4'b0011);
        end else begin
            laneEn = '1;
        end
    end

    // store data replicated so the enabled lanes always hold it
    always_comb begin
        if (isByte) begin
            laneData = {4{req.storeData[7:0]}};
        end else if (isHalf) begin
            laneData = {2{req.storeData[15:0]}};
        end else begin
            laneData = req.storeData;
        end
    end

    // bytes never fault
    always_comb begin
        misaligned = 1'b0;
        if (isHalf && offset[0]) begin
            misaligned = 1'b1;
        end
        if (isWord && (offset != 2'b00)) begin
            misaligned = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== loadFormatter.sv ====
`timescale 1ns/100ps
`default_nettype none

module loadFormatter import memPkg::*; (
    input  memOp_t    op,
    input  addr_t     addr,
    input  dataWord_t rdata,
    output dataWord_t loadData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // pick the addressed lane out of the read word
    always_comb begin
        unique case (addr[1:0])
            2'b00:   byteSel = rdata[7:0];
            2'b01:   byteSel = rdata[15:8];
            2'b10:   byteSel = rdata[23:16];
            default: byteSel = rdata[31:24];
        endcase
    end

    assign halfSel = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        unique case (op)
            LB:      loadData = {{24{byteSel[7]}}, byteSel};
            LBU:     loadData = {24'd0, byteSel};
            LH:      loadData = {{16{halfSel[15]}}, halfSel};
            LHU:     loadData = {16'd0, halfSel};
            default: loadData = rdata;   // LW, stores don't care
        endcase
    end

endmodule

`default_nettype wire

// ==== memAccessCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module memAccessCtrl import memPkg::*; (
    input  wire       clk,
    input  wire       reset,

    input  wire       inReq,
    input  memReq_t   in,
    output logic      inAck,

    output memReq_t   heldReq,
    input  byteEn_t   laneEn,
    input  dataWord_t laneData,
    input  wire       misaligned,
    input  dataWord_t loadData,

    output logic      busReq,
    output busReq_t   bus,
    input  wire       busAck,

    output logic      outReq,
    output memResp_t  out,
    input  wire       outAck
);

    typedef enum logic [2:0] {
        stIdle,
        stInAck,
        stBusReq,
        stBusRel,
        stOutReq,
        stOutRel
    } state_t;

    state_t    state;
    logic      isLoad;
    dataWord_t rdReg;     // extended load result
    memResp_t  resp;

    assign isLoad = heldReq.op inside {LB, LBU, LH, LHU, LW};

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= stIdle;
            inAck  <= 1'b0;
            busReq <= 1'b0;
            outReq <= 1'b0;
        end else begin
            unique case (state)
                stIdle: begin
                    if (inReq) begin
                        inAck <= 1'b1;
                        state <= stInAck;
                    end
                end
                stInAck: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        // address errors skip the bus entirely
                        state <= misaligned ? stOutReq : stBusReq;
                    end
                end
                stBusReq: begin
                    if (!busReq) begin
                        busReq <= 1'b1;
                    end else if (busAck) begin
                        busReq <= 1'b0;
                        state  <= stBusRel;
                    end
                end
                stBusRel: begin
                    if (!busAck) begin
                        state <= stOutReq;
                    end
                end
                stOutReq: begin
                    if (!outReq) begin
                        outReq <= 1'b1;
                    end else if (outAck) begin
                        outReq <= 1'b0;
                        state  <= stOutRel;
                    end
                end
                stOutRel: begin
                    if (!outAck) begin
                        state <= stIdle;   // response fully handed off
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && inReq) begin
            heldReq <= in;
        end
        if (state == stBusReq && busReq && busAck) begin
            rdReg <= loadData;   // rdata only valid while ack is high
        end
        if (state == stOutReq && !outReq) begin
            out <= resp;   // frozen until outAck drops
        end
    end

    // bus side straight from the held access
    always_comb begin
        bus.addr  = {heldReq.addr[31:2], 2'b00};
        bus.wen   = isLoad ? byteEn_t'(0) : laneEn;
        bus.wdata = laneData;
    end

    always_comb begin
        resp.dest = heldReq.dest;
        if (misaligned) begin
            resp.regWrite = 1'b0;
            resp.data     = '0;
            resp.excValid = 1'b1;
            resp.excCode  = isLoad ? EXC_ADEL : EXC_ADES;
            resp.badVAddr = heldReq.addr;
        end else begin
            resp.regWrite = isLoad;
            resp.data     = isLoad ? rdReg : dataWord_t'(0);
            resp.excValid = 1'b0;
            resp.excCode  = '0;
            resp.badVAddr = '0;
        end
    end

endmodule

`default_nettype wire

// ==== memStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memStage import memPkg::*; (
    input  wire       clk,
    input  wire       reset,

    input  wire       inReq,
    input  memReq_t   in,
    output logic      inAck,

    output logic      busReq,
    output busReq_t   bus,
    input  wire       busAck,
    input  dataWord_t busRdata,

    output logic      outReq,
    output memResp_t  out,
    input  wire       outAck
);

    memReq_t   heldReq;
    byteEn_t   laneEn;
    dataWord_t laneData;
    logic      misaligned;
    dataWord_t loadData;

    memAccessCtrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .inReq      (inReq),
        .in         (in),
        .inAck      (inAck),
        .heldReq    (heldReq),
        .laneEn     (laneEn),
        .laneData   (laneData),
        .misaligned (misaligned),
        .loadData   (loadData),
        .busReq     (busReq),
        .bus        (bus),
        .busAck     (busAck),
        .outReq     (outReq),
        .out        (out),
        .outAck     (outAck)
    );

    laneMapper u_lanes (
        .req        (heldReq),
        .laneEn     (laneEn),
        .laneData   (laneData),
        .misaligned (misaligned)
    );

    loadFormatter u_load (
        .op       (heldReq.op),
        .addr     (heldReq.addr),
        .rdata    (busRdata),
        .loadData (loadData)
    );

endmodule

`default_nettype wire

// ==== tbMemStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbMemStage import memPkg::*; ();

    logic      clk;
    logic      reset;
    logic      inReq;
    memReq_t   reqIn;
    logic      inAck;
    logic      busReq;
    busReq_t   busOut;
    logic      busAck;
    dataWord_t busRdata;
    logic      outReq;
    memResp_t  respOut;
    logic      outAck;

    dataWord_t busMem [64];     // what the bus responder holds
    dataWord_t modelMem [64];   // reference copy
    addr_t     storedAddr [$];
    integer    seed;
    int        errorCount;
    int        checkCount;
    bit        hung;
    bit        outPending;      // response checked, output handshake not yet closed
    bit        pendBad;
    dataWord_t pendData;
    logic      lastInAck = 1'b0;

    memStage i_dut (
        .clk      (clk),
        .reset    (reset),
        .inReq    (inReq),
        .in       (reqIn),
        .inAck    (inAck),
        .busReq   (busReq),
        .bus      (busOut),
        .busAck   (busAck),
        .busRdata (busRdata),
        .outReq   (outReq),
        .out      (respOut),
        .outAck   (outAck)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // inputs change just after the edge, outputs are settled by then
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] nextRand();
        nextRand = $random(seed);
    endfunction

    function automatic dataWord_t fillWord(int i);
        fillWord = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // a new request waits until the previous response is fully handed off
    always @(negedge clk) begin
        if (inAck === 1'b1 && lastInAck !== 1'b1) begin
            checkValue("outReq or outAck at inAck rise", 32'(outReq | outAck), 32'd0);
        end
        lastInAck = inAck;
    end

    function automatic logic readSignal(int sel);
        case (sel)
            0:       readSignal = inAck;
            1:       readSignal = busReq;
            default: readSignal = outReq;
        endcase
    endfunction

    function automatic string signalName(int sel);
        case (sel)
            0:       signalName = "inAck";
            1:       signalName = "busReq";
            default: signalName = "outReq";
        endcase
    endfunction

    // poll one handshake output, optionally watching for a stray bus request
    task automatic waitLevel(input int sel, input logic level, input bit noBus);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 20) begin
            if (noBus) checkValue("busReq", 32'(busReq), 32'd0);
            if (readSignal(sel) === level) begin
                seen = 1'b1;
            end else begin
                tick();
                n++;
            end
        end
        if (!seen) begin
            $display("timeout at %0t ns: %s did not go to %0d within 20 cycles",
                     $time, signalName(sel), level);
            errorCount++;
            hung = 1'b1;
        end
    endtask

    task automatic partnerDelay();
        int delay;
        delay = int'(nextRand() % 32'd4);
        repeat (delay) tick();
    endtask

    // close the output handshake of the last checked response
    task automatic releaseOutput();
        if (hung || !outPending) return;
        outPending = 1'b0;
        partnerDelay();
        outAck = 1'b1;
        waitLevel(2, 1'b0, pendBad);
        if (hung) return;
        checkValue("out.data held", respOut.data, pendData);
        outAck = 1'b0;
    endtask

    // mode 0 aligned, 1 misaligned, 2 anything
    function automatic memReq_t makeReq(memOp_t op, int mode);
        memReq_t r;
        addr_t   a;
        a = nextRand();
        if (op inside {LH, LHU, SH}) begin
            if (mode == 0) a[0] = 1'b0;
            if (mode == 1) a[0] = 1'b1;
        end else if (op inside {LW, SW}) begin
            if (mode == 0) a[1:0] = 2'b00;
            if (mode == 1) a[1:0] = 2'(32'd1 + nextRand() % 32'd3);
        end
        r.op        = op;
        r.addr      = a;
        r.storeData = nextRand();
        r.dest      = 5'(nextRand());
        makeReq     = r;
    endfunction

    task automatic runAccess(input memReq_t r);
        logic [1:0] off;
        logic [5:0] idx;
        logic [5:0] busIdx;
        int         size;
        bit         isLoadOp;
        bit         bad;
        byteEn_t    expWen;
        dataWord_t  expWdata;
        dataWord_t  word;
        dataWord_t  expData;
        logic [4:0] expCode;
        if (hung) return;
        off = r.addr[1:0];
        idx = r.addr[7:2];
        isLoadOp = r.op inside {LB, LBU, LH, LHU, LW};
        case (r.op)
            LB, LBU, SB: size = 1;
            LH, LHU, SH: size = 2;
            default:     size = 4;
        endcase
        bad = (size == 2 && off[0]) || (size == 4 && off != 2'b00);
        expWen = byteEn_t'(((1 << size) - 1) << off);
        case (size)
            1:       expWdata = {4{r.storeData[7:0]}};
            2:       expWdata = {2{r.storeData[15:0]}};
            default: expWdata = r.storeData;
        endcase
        word = modelMem[idx] >> (8 * off);   // addressed lane moved down
        case (r.op)
            LB:      expData = {{24{word[7]}}, word[7:0]};
            LBU:     expData = {24'd0, word[7:0]};
            LH:      expData = {{16{word[15]}}, word[15:0]};
            LHU:     expData = {16'd0, word[15:0]};
            LW:      expData = modelMem[idx];
            default: expData = 32'd0;
        endcase
        if (bad) expData = 32'd0;
        if (!bad && !isLoadOp) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (expWen[lane]) modelMem[idx][8*lane +: 8] = expWdata[8*lane +: 8];
            end
        end
        expCode = bad ? (isLoadOp ? 5'd4 : 5'd5) : 5'd0;

        reqIn = r;
        inReq = 1'b1;
        releaseOutput();   // next request already waiting
        if (hung) return;
        waitLevel(0, 1'b1, 1'b0);
        if (hung) return;
        inReq = 1'b0;
        waitLevel(0, 1'b0, 1'b0);
        if (hung) return;

        if (!bad) begin
            waitLevel(1, 1'b1, 1'b0);
            if (hung) return;
            checkValue("bus.addr", busOut.addr, {r.addr[31:2], 2'b00});
            checkValue("bus.wen", 32'(busOut.wen), isLoadOp ? 32'd0 : 32'(expWen));
            if (!isLoadOp) checkValue("bus.wdata", busOut.wdata, expWdata);
            partnerDelay();
            busIdx = busOut.addr[7:2];   // responder trusts the DUT address
            for (int lane = 0; lane < 4; lane++) begin
                if (busOut.wen[lane]) busMem[busIdx][8*lane +: 8] = busOut.wdata[8*lane +: 8];
            end
            busRdata = busMem[busIdx];
            busAck   = 1'b1;
            waitLevel(1, 1'b0, 1'b0);
            if (hung) return;
            busAck   = 1'b0;
            busRdata = nextRand();   // garbage outside the ack window
            if (!isLoadOp) checkValue("memory word", busMem[idx], modelMem[idx]);
        end

        waitLevel(2, 1'b1, bad);
        if (hung) return;
        checkValue("out.regWrite", 32'(respOut.regWrite), 32'(!bad && isLoadOp));
        checkValue("out.dest", 32'(respOut.dest), 32'(r.dest));
        checkValue("out.data", respOut.data, expData);
        checkValue("out.excValid", 32'(respOut.excValid), 32'(bad));
        checkValue("out.excCode", 32'(respOut.excCode), 32'(expCode));
        checkValue("out.badVAddr", respOut.badVAddr, bad ? r.addr : 32'd0);
        pendData   = respOut.data;
        pendBad    = bad;
        outPending = 1'b1;
    endtask

    task automatic reportTest(input string name, input int accesses, input int errsBefore);
        $display("test %s finished: %0d accesses, %0d failed checks",
                 name, accesses, errorCount - errsBefore);
    endtask

    initial begin
        int      errsBefore;
        int      k;
        memOp_t  op;
        memReq_t r;
        logic [31:0] pick;
        seed       = 32'h226bc641;
        errorCount = 0;
        checkCount = 0;
        hung       = 1'b0;
        outPending = 1'b0;
        pendBad    = 1'b0;
        pendData   = '0;
        reset      = 1'b1;
        inReq      = 1'b0;
        reqIn      = '0;
        busAck     = 1'b0;
        busRdata   = '0;
        outAck     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            busMem[i]   = fillWord(i);
            modelMem[i] = busMem[i];
        end

        errsBefore = errorCount;
        repeat (10) tick();
        reset = 1'b0;
        tick();
        checkValue("inAck", 32'(inAck), 32'd0);
        checkValue("busReq", 32'(busReq), 32'd0);
        checkValue("outReq", 32'(outReq), 32'd0);
        reportTest("reset", 0, errsBefore);

        errsBefore = errorCount;
        for (int i = 0; i < 30; i++) begin
            pick = nextRand() % 32'd3;
            op = (pick == 0) ? SB : (pick == 1) ? SH : SW;
            r = makeReq(op, 0);
            storedAddr.push_back(r.addr);
            runAccess(r);
        end
        releaseOutput();
        reportTest("aligned stores", 30, errsBefore);

        // loads go back to words the stores touched
        errsBefore = errorCount;
        for (int i = 0; i < 30; i++) begin
            pick = nextRand() % 32'd5;
            op = (pick == 0) ? LB : (pick == 1) ? LBU : (pick == 2) ? LH :
                 (pick == 3) ? LHU : LW;
            r = makeReq(op, 0);
            k = int'(nextRand() % 32'(storedAddr.size()));
            r.addr[31:2] = storedAddr[k][31:2];
            runAccess(r);
        end
        releaseOutput();
        reportTest("aligned loads", 30, errsBefore);

        errsBefore = errorCount;
        for (int i = 0; i < 20; i++) begin
            pick = nextRand() % 32'd5;
            op = (pick == 0) ? LH : (pick == 1) ? LHU : (pick == 2) ? LW :
                 (pick == 3) ? SH : SW;
            runAccess(makeReq(op, 1));
        end
        releaseOutput();
        reportTest("misaligned", 20, errsBefore);

        errsBefore = errorCount;
        for (int i = 0; i < 200; i++) begin
            pick = nextRand();
            op = memOp_t'(pick[2:0]);
            runAccess(makeReq(op, 2));
        end
        releaseOutput();
        reportTest("random mix", 200, errsBefore);

        $display("checks %0d, failed %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
memPkg.sv
laneMapper.sv
loadFormatter.sv
memAccessCtrl.sv
memStage.sv
tbMemStage.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tbMemStage -o simMemStage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simMemStage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0
